// File: verilog.f
+incdir+.
pic_cfg_pkg.sv
pic_irq_pkg.sv
pic_command_decoder.sv
pic_ir_channel.sv
pic_priority_ack.sv
pic_controller.sv
pic_controller_tb.sv

// File: pic_controller_tb.sv
`timescale 1ns/100ps

module pic_controller_tb;
    import pic_cfg_pkg::*;
    import pic_irq_pkg::*;

    localparam int        CLK_PERIOD   = 10;
    localparam int        RESET_CYCLES = 8;
    // Bound on any wait for intr or vec_valid
    localparam int        WAIT_CYCLES  = 12;
    localparam int        MAX_STEPS    = 96;
    localparam int        MAX_TESTS    = 8;
    // ICW2 word, vector base 5'h09
    localparam pic_word_t BASE         = 8'h48;

    // Step kinds
    localparam int K_WR  = 0;
    localparam int K_IR  = 1;
    localparam int K_ACK = 2;
    localparam int K_RD  = 3;
    localparam int K_INT = 4;

    logic      write_ICW_1;
    logic      write_ICW_1_rst;
    logic      wr;
    logic      rd;
    logic      a0;
    logic      inta;
    pic_word_t din;
    irq_vec_t  ir;
    logic      intr;
    logic      vec_valid;
    pic_word_t dout;

    // Step table
    int        step_kind [MAX_STEPS];
    logic      step_a0   [MAX_STEPS];
    pic_word_t step_data [MAX_STEPS];
    pic_word_t step_exp  [MAX_STEPS];
    logic      step_rnd  [MAX_STEPS];
    int        step_test [MAX_STEPS];
    string     test_names[MAX_TESTS];
    int        test_errs [MAX_TESTS];

    int        n_steps;
    int        cur_test;
    int        active_test;
    int        errors;
    int        failed_tests;
    integer    seed;
    irq_vec_t  rnd_val;
    logic      table_ready;

    pic_controller u_pic_controller (
        .write_ICW_1     (write_ICW_1),
        .write_ICW_1_rst (write_ICW_1_rst),
        .wr              (wr),
        .rd              (rd),
        .a0              (a0),
        .din             (din),
        .ir              (ir),
        .inta            (inta),
        .intr            (intr),
        .vec_valid       (vec_valid),
        .dout            (dout)
    );

    initial begin
        write_ICW_1 = 1'b0;
        forever #(CLK_PERIOD / 2) write_ICW_1 = ~write_ICW_1;
    end

    // Base times eight plus the line number
    function automatic vector_t expected_vector(input int line);
        return vector_t'((BASE >> 3) * 8 + line);
    endfunction

    task automatic begin_test(input string name);
        cur_test++;
        test_names[cur_test] = name;
        test_errs[cur_test]  = 0;
    endtask

    task automatic add_step(input int kind, input logic a, input pic_word_t data,
                            input pic_word_t exp, input logic rnd);
        step_kind[n_steps] = kind;
        step_a0[n_steps]   = a;
        step_data[n_steps] = data;
        step_exp[n_steps]  = exp;
        step_rnd[n_steps]  = rnd;
        step_test[n_steps] = cur_test;
        n_steps++;
    endtask

    // ICW1, ICW2, ICW4, then OCW1 and OCW3
    task automatic add_init(input pic_word_t icw1, input pic_word_t icw4,
                            input pic_word_t ocw1, input pic_word_t ocw3);
        add_step(K_WR, 1'b0, icw1, 8'h00, 1'b0);
        add_step(K_WR, 1'b1, BASE, 8'h00, 1'b0);
        add_step(K_WR, 1'b1, icw4, 8'h00, 1'b0);
        add_step(K_WR, 1'b1, ocw1, 8'h00, 1'b0);
        add_step(K_WR, 1'b0, ocw3, 8'h00, 1'b0);
    endtask

    task automatic build_table();
        begin_test("masked line shows in IRR only");
        add_init(8'h11, 8'h00, 8'hff, 8'h0a);
        add_step(K_IR,  1'b0, 8'h08, 8'h00, 1'b0);
        add_step(K_INT, 1'b0, 8'h00, 8'h00, 1'b0);
        add_step(K_RD,  1'b0, 8'h00, 8'h08, 1'b0);
        begin_test("unmasked edge is vectored");
        add_step(K_IR,  1'b0, 8'h00, 8'h00, 1'b0);
        add_init(8'h11, 8'h00, 8'h00, 8'h0b);
        add_step(K_IR,  1'b0, 8'h20, 8'h00, 1'b0);
        add_step(K_INT, 1'b0, 8'h00, 8'h01, 1'b0);
        add_step(K_ACK, 1'b0, 8'h00, expected_vector(5), 1'b0);
        add_step(K_RD,  1'b0, 8'h00, 8'h20, 1'b0);
        add_step(K_INT, 1'b0, 8'h00, 8'h00, 1'b0);
        begin_test("fixed priority with non-specific EOI");
        add_step(K_IR,  1'b0, 8'h00, 8'h00, 1'b0);
        add_step(K_WR,  1'b0, 8'h20, 8'h00, 1'b0);
        add_step(K_RD,  1'b0, 8'h00, 8'h00, 1'b0);
        add_step(K_IR,  1'b0, 8'h44, 8'h00, 1'b0);
        add_step(K_INT, 1'b0, 8'h00, 8'h01, 1'b0);
        add_step(K_ACK, 1'b0, 8'h00, expected_vector(2), 1'b0);
        add_step(K_WR,  1'b0, 8'h20, 8'h00, 1'b0);
        add_step(K_INT, 1'b0, 8'h00, 8'h01, 1'b0);
        add_step(K_ACK, 1'b0, 8'h00, expected_vector(6), 1'b0);
        add_step(K_WR,  1'b0, 8'h20, 8'h00, 1'b0);
        add_step(K_RD,  1'b0, 8'h00, 8'h00, 1'b0);
        begin_test("specific EOI clears one ISR bit");
        add_step(K_IR,  1'b0, 8'h00, 8'h00, 1'b0);
        add_step(K_IR,  1'b0, 8'h10, 8'h00, 1'b0);
        add_step(K_INT, 1'b0, 8'h00, 8'h01, 1'b0);
        add_step(K_ACK, 1'b0, 8'h00, expected_vector(4), 1'b0);
        // IR1 outranks IR4 in service
        add_step(K_IR,  1'b0, 8'h12, 8'h00, 1'b0);
        add_step(K_INT, 1'b0, 8'h00, 8'h01, 1'b0);
        add_step(K_ACK, 1'b0, 8'h00, expected_vector(1), 1'b0);
        add_step(K_RD,  1'b0, 8'h00, 8'h12, 1'b0);
        add_step(K_WR,  1'b0, 8'h64, 8'h00, 1'b0);
        add_step(K_RD,  1'b0, 8'h00, 8'h02, 1'b0);
        add_step(K_WR,  1'b0, 8'h61, 8'h00, 1'b0);
        add_step(K_RD,  1'b0, 8'h00, 8'h00, 1'b0);
        begin_test("automatic EOI");
        add_step(K_IR,  1'b0, 8'h00, 8'h00, 1'b0);
        add_init(8'h11, 8'h02, 8'h00, 8'h0b);
        add_step(K_IR,  1'b0, 8'h80, 8'h00, 1'b0);
        add_step(K_INT, 1'b0, 8'h00, 8'h01, 1'b0);
        add_step(K_ACK, 1'b0, 8'h00, expected_vector(7), 1'b0);
        add_step(K_RD,  1'b0, 8'h00, 8'h00, 1'b0);
        add_step(K_INT, 1'b0, 8'h00, 8'h00, 1'b0);
        begin_test("level mode IRR follows the line");
        add_step(K_IR,  1'b0, 8'h00, 8'h00, 1'b0);
        add_init(8'h19, 8'h00, 8'hff, 8'h0a);
        add_step(K_IR,  1'b0, 8'h04, 8'h00, 1'b0);
        add_step(K_RD,  1'b0, 8'h00, 8'h04, 1'b0);
        add_step(K_IR,  1'b0, 8'h00, 8'h00, 1'b0);
        add_step(K_RD,  1'b0, 8'h00, 8'h00, 1'b0);
        begin_test("random line pattern in IRR");
        add_init(8'h11, 8'h00, 8'hff, 8'h0a);
        add_step(K_IR,  1'b0, 8'h00, 8'h00, 1'b1);
        add_step(K_RD,  1'b0, 8'h00, 8'h00, 1'b1);
        add_step(K_INT, 1'b0, 8'h00, 8'h00, 1'b0);
    endtask

    task automatic note_error();
        errors++;
        test_errs[active_test]++;
    endtask

    task automatic host_write(input logic a, input pic_word_t data);
        @(posedge write_ICW_1);
        wr  <= 1'b1;
        a0  <= a;
        din <= data;
        @(posedge write_ICW_1);
        wr  <= 1'b0;
    endtask

    // Settling time for edge detect and IRR
    task automatic set_lines(input irq_vec_t v);
        @(posedge write_ICW_1);
        ir <= v;
        repeat (3) @(posedge write_ICW_1);
    endtask

    // Two one-cycle pulses, one idle cycle apart
    task automatic acknowledge();
        @(posedge write_ICW_1);
        inta <= 1'b1;
        @(posedge write_ICW_1);
        inta <= 1'b0;
        @(posedge write_ICW_1);
        inta <= 1'b1;
        @(posedge write_ICW_1);
        inta <= 1'b0;
    endtask

    task automatic read_reg(output irq_vec_t got);
        @(posedge write_ICW_1);
        rd <= 1'b1;
        @(negedge write_ICW_1);
        got = dout;
        @(posedge write_ICW_1);
        rd <= 1'b0;
    endtask

    task automatic check_reg(input irq_vec_t got, input irq_vec_t exp, input int step);
        if (got !== exp) begin
            $display("[ERROR] %0t: step %0d register read 0x%02h, expected 0x%02h",
                     $time, step, got, exp);
            note_error();
        end
    endtask

    task automatic check_vector(input vector_t exp, input int step);
        int n;
        n = 0;
        @(negedge write_ICW_1);
        while (!vec_valid && n < WAIT_CYCLES) begin
            @(negedge write_ICW_1);
            n++;
        end
        if (!vec_valid) begin
            $display("Step %0d: vec_valid did not rise within %0d cycles of the acknowledge",
                     step, WAIT_CYCLES);
            note_error();
        end else if (dout !== exp) begin
            $display("[ERROR] %0t: step %0d vector 0x%02h, expected 0x%02h",
                     $time, step, dout, exp);
            note_error();
        end
    endtask

    task automatic check_int(input logic exp, input int step);
        int n;
        n = 0;
        @(negedge write_ICW_1);
        while (intr !== exp && n < WAIT_CYCLES) begin
            @(negedge write_ICW_1);
            n++;
        end
        if (intr !== exp) begin
            $display("[ERROR] %0t: step %0d intr %b, expected %b", $time, step, intr, exp);
            note_error();
        end
    endtask

    task automatic run_step(input int i);
        irq_vec_t got;
        case (step_kind[i])
            K_WR: host_write(step_a0[i], step_data[i]);
            K_IR: begin
                if (step_rnd[i]) begin
                    rnd_val = irq_vec_t'($random(seed));
                    set_lines(rnd_val);
                end else begin
                    set_lines(step_data[i]);
                end
            end
            K_ACK: begin
                acknowledge();
                check_vector(step_exp[i], i);
            end
            K_RD: begin
                read_reg(got);
                check_reg(got, step_rnd[i] ? rnd_val : step_exp[i], i);
            end
            default: check_int(step_exp[i][0], i);
        endcase
    endtask

    task automatic report_test(input int t);
        if (test_errs[t] == 0) begin
            $display("Test %0d (%s): PASS", t, test_names[t]);
        end else begin
            $display("Test %0d (%s): FAIL, %0d errors", t, test_names[t], test_errs[t]);
            failed_tests++;
        end
    endtask

    // Watchdog sized from the step count
    initial begin
        wait (table_ready === 1'b1);
        repeat (RESET_CYCLES + n_steps * 50) @(posedge write_ICW_1);
        $display("Timeout: the step table did not finish within its cycle budget");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        write_ICW_1_rst = 1'b1;
        wr              = 1'b0;
        rd              = 1'b0;
        a0              = 1'b0;
        inta            = 1'b0;
        din             = '0;
        ir              = '0;
        seed            = 32'ha8a9_374d;
        rnd_val         = '0;
        n_steps         = 0;
        cur_test        = -1;
        active_test     = 0;
        errors          = 0;
        failed_tests    = 0;
        table_ready     = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge write_ICW_1);
        write_ICW_1_rst <= 1'b0;
        for (int i = 0; i < n_steps; i++) begin
            active_test = step_test[i];
            run_step(i);
            if ((i == n_steps - 1) || (step_test[i + 1] != step_test[i])) begin
                report_test(step_test[i]);
            end
        end
        $display("Summary: %0d tests, %0d failed, %0d errors",
                 cur_test + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: pic_controller.sv
`timescale 1ns/100ps
`include "pic_macros.svh"

module pic_controller (
    input  logic                  write_ICW_1,
    input  logic                  write_ICW_1_rst,
    input  logic                  wr,
    input  logic                  rd,
    input  logic                  a0,
    input  pic_cfg_pkg::pic_word_t din,
    input  pic_irq_pkg::irq_vec_t  ir,
    input  logic                  inta,
    output logic                  intr,
    output logic                  vec_valid,
    output pic_cfg_pkg::pic_word_t dout
);
    import pic_cfg_pkg::*;
    import pic_irq_pkg::*;

    // Configuration from the decoder
    logic      level_mode;
    logic      aeoi;
    logic      read_isr;
    logic      init_clear;
    logic      eoi_nonspecific;
    vec_base_t vec_base;
    irq_vec_t  mask;
    irq_vec_t  eoi_specific;

    // Per-line state and controls
    irq_vec_t  grant;
    irq_vec_t  eoi_clear;
    irq_vec_t  irr_vec;
    irq_vec_t  isr_vec;
    irq_vec_t  request_vec;

    pic_command_decoder u_command_decoder (
        .write_ICW_1     (write_ICW_1),
        .write_ICW_1_rst (write_ICW_1_rst),
        .wr              (wr),
        .a0              (a0),
        .din             (din),
        .level_mode      (level_mode),
        .aeoi            (aeoi),
        .read_isr        (read_isr),
        .vec_base        (vec_base),
        .mask            (mask),
        .eoi_specific    (eoi_specific),
        .eoi_nonspecific (eoi_nonspecific),
        .init_clear      (init_clear)
    );

    // One channel per IR line
    for (genvar i = 0; i < `PIC_NUM_IR; i++) begin : g_ir
        pic_ir_channel u_ir_channel (
            .write_ICW_1     (write_ICW_1),
            .write_ICW_1_rst (write_ICW_1_rst),
            .ir_line         (ir[i]),
            .level_mode      (level_mode),
            .mask_bit        (mask[i]),
            .grant_bit       (grant[i]),
            .eoi_bit         (eoi_clear[i]),
            .init_clear      (init_clear),
            .irr             (irr_vec[i]),
            .isr             (isr_vec[i]),
            .request         (request_vec[i])
        );
    end

    pic_priority_ack u_priority_ack (
        .write_ICW_1     (write_ICW_1),
        .write_ICW_1_rst (write_ICW_1_rst),
        .inta            (inta),
        .rd              (rd),
        .aeoi            (aeoi),
        .read_isr        (read_isr),
        .vec_base        (vec_base),
        .request_vec     (request_vec),
        .irr_vec         (irr_vec),
        .isr_vec         (isr_vec),
        .eoi_specific    (eoi_specific),
        .eoi_nonspecific (eoi_nonspecific),
        .intr            (intr),
        .grant           (grant),
        .eoi_clear       (eoi_clear),
        .vec_valid       (vec_valid),
        .dout            (dout)
    );

endmodule

// File: pic_priority_ack.sv
`timescale 1ns/100ps
`include "pic_macros.svh"

module pic_priority_ack (
    input  logic                   write_ICW_1,
    input  logic                   write_ICW_1_rst,
    input  logic                   inta,
    input  logic                   rd,
    input  logic                   aeoi,
    input  logic                   read_isr,
    input  pic_cfg_pkg::vec_base_t  vec_base,
    input  pic_irq_pkg::irq_vec_t   request_vec,
    input  pic_irq_pkg::irq_vec_t   irr_vec,
    input  pic_irq_pkg::irq_vec_t   isr_vec,
    input  pic_irq_pkg::irq_vec_t   eoi_specific,
    input  logic                   eoi_nonspecific,
    output logic                   intr,
    output pic_irq_pkg::irq_vec_t   grant,
    output pic_irq_pkg::irq_vec_t   eoi_clear,
    output logic                   vec_valid,
    output pic_cfg_pkg::pic_word_t  dout
);
    import pic_irq_pkg::*;

    // Lowest set bit wins, IR0 first
    function automatic irq_num_t first_set(input irq_vec_t v);
        irq_num_t n;
        n = '0;
        for (int i = `PIC_NUM_IR - 1; i >= 0; i--) begin
            if (v[i]) begin
                n = irq_num_t'(i);
            end
        end
        return n;
    endfunction

    ack_phase_t phase;
    irq_num_t   req_num;
    irq_num_t   isr_num;
    irq_num_t   ack_num;
    // First pulse found a real request
    logic       ack_hit;
    logic       int_cond;
    logic       first_pulse;
    logic       second_pulse;
    irq_vec_t   aeoi_clear;
    vector_t    vector;

    assign req_num = first_set(request_vec);
    assign isr_num = first_set(isr_vec);

    // Request must outrank everything in service
    assign int_cond = (|request_vec) && (!(|isr_vec) || (req_num < isr_num));

    assign first_pulse  = inta && (phase == ACK_IDLE);
    assign second_pulse = inta && (phase == ACK_FIRST);

    // Moves the line from IRR to ISR
    assign grant = (first_pulse && int_cond) ? (irq_vec_t'(1) << req_num) : '0;

    // AEOI ends service on the second pulse edge
    assign aeoi_clear = (second_pulse && aeoi && ack_hit) ? (irq_vec_t'(1) << ack_num) : '0;

    always_comb begin
        eoi_clear = eoi_specific | aeoi_clear;
        // Non-specific EOI ends the highest in service
        if (eoi_nonspecific && (|isr_vec)) begin
            eoi_clear = eoi_clear | (irq_vec_t'(1) << isr_num);
        end
    end

    // Base times eight plus the line
    assign vector    = {vec_base, ack_num};
    assign vec_valid = (phase == ACK_SECOND);

    // Vector beats a register read
    assign dout = vec_valid ? vector :
                  rd        ? (read_isr ? isr_vec : irr_vec) : '0;

    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            phase   <= ACK_IDLE;
            ack_num <= '0;
            ack_hit <= 1'b0;
            intr    <= 1'b0;
        end else begin
            intr <= int_cond;
            case (phase)
                ACK_IDLE: begin
                    if (inta) begin
                        // No request left means spurious IR7
                        ack_num <= int_cond ? req_num : '1;
                        ack_hit <= int_cond;
                        phase   <= ACK_FIRST;
                    end
                end
                ACK_FIRST: begin
                    if (inta) begin
                        phase <= ACK_SECOND;
                    end
                end
                default: begin
                    phase <= ACK_IDLE;
                end
            endcase
        end
    end

endmodule

// File: pic_ir_channel.sv
`timescale 1ns/100ps

module pic_ir_channel (
    input  logic write_ICW_1,
    input  logic write_ICW_1_rst,
    input  logic ir_line,
    input  logic level_mode,
    input  logic mask_bit,
    input  logic grant_bit,
    input  logic eoi_bit,
    input  logic init_clear,
    output logic irr,
    output logic isr,
    output logic request
);

    // Line value from the previous edge
    logic prev_ir;
    logic rise;

    assign rise = ir_line & ~prev_ir;

    // Masked lines still show in IRR
    assign request = irr & ~mask_bit;

    // Edge history keeps running through init
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            prev_ir <= 1'b0;
        end else begin
            prev_ir <= ir_line;
        end
    end

    // Request register
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            irr <= 1'b0;
        end else if (init_clear || grant_bit) begin
            irr <= 1'b0;
        end else if (level_mode) begin
            // Level mode tracks the line
            irr <= ir_line;
        end else if (rise) begin
            irr <= 1'b1;
        end
    end

    // In-service bit, set by the first acknowledge
    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            isr <= 1'b0;
        end else if (init_clear) begin
            isr <= 1'b0;
        end else if (grant_bit) begin
            isr <= 1'b1;
        end else if (eoi_bit) begin
            isr <= 1'b0;
        end
    end

endmodule

// File: pic_command_decoder.sv
`timescale 1ns/100ps
`include "pic_macros.svh"

module pic_command_decoder (
    input  logic                  write_ICW_1,
    input  logic                  write_ICW_1_rst,
    input  logic                  wr,
    input  logic                  a0,
    input  pic_cfg_pkg::pic_word_t din,
    output logic                  level_mode,
    output logic                  aeoi,
    output logic                  read_isr,
    output pic_cfg_pkg::vec_base_t vec_base,
    output pic_irq_pkg::irq_vec_t  mask,
    output pic_irq_pkg::irq_vec_t  eoi_specific,
    output logic                  eoi_nonspecific,
    output logic                  init_clear
);
    import pic_cfg_pkg::*;
    import pic_irq_pkg::*;

    // Initialization progress, both low when ready
    logic    expect_icw2;
    logic    expect_icw4;
    // ICW4 requested by the last ICW1
    logic    need_icw4;

    logic    icw1_wr;
    logic    ocw23_wr;
    logic    hi_wr;
    logic    ocw2_wr;
    logic    ocw3_wr;
    ocw23_u  ocw;

    // Address decode of the write
    assign icw1_wr  = wr & ~a0 & din[`PIC_ICW1_SEL];
    assign ocw23_wr = wr & ~a0 & ~din[`PIC_ICW1_SEL];
    assign hi_wr    = wr & a0;

    // Same word read as OCW2 or OCW3
    assign ocw     = din;
    assign ocw2_wr = ocw23_wr & ~din[`PIC_OCW_SEL3];
    assign ocw3_wr = ocw23_wr & din[`PIC_OCW_SEL3];

    // Channels drop IRR and ISR on the ICW1 edge
    assign init_clear = icw1_wr;

    // Specific EOI as a one-hot of the named level
    assign eoi_specific = (ocw2_wr && ocw.ocw2.eoi && ocw.ocw2.sl) ?
                          (irq_vec_t'(1) << ocw.ocw2.level) : '0;

    // Non-specific EOI, resolved against ISR downstream
    assign eoi_nonspecific = ocw2_wr & ocw.ocw2.eoi & ~ocw.ocw2.sl;

    always_ff @(posedge write_ICW_1 or posedge write_ICW_1_rst) begin
        if (write_ICW_1_rst) begin
            expect_icw2 <= 1'b0;
            expect_icw4 <= 1'b0;
            need_icw4   <= 1'b0;
            level_mode  <= 1'b0;
            aeoi        <= 1'b0;
            read_isr    <= 1'b0;
            vec_base    <= '0;
            mask        <= '1;
        end else if (icw1_wr) begin
            // Restart, ICW2 always comes next
            expect_icw2 <= 1'b1;
            expect_icw4 <= 1'b0;
            need_icw4   <= din[`PIC_ICW1_IC4];
            level_mode  <= din[`PIC_ICW1_LTIM];
            aeoi        <= 1'b0;
            read_isr    <= 1'b0;
            mask        <= '1;
        end else begin
            if (hi_wr && expect_icw2) begin
                // ICW2, upper bits of the vector
                vec_base    <= din[`PIC_DATA_W-1 -: `PIC_BASE_W];
                expect_icw2 <= 1'b0;
                expect_icw4 <= need_icw4;
            end else if (hi_wr && expect_icw4) begin
                aeoi        <= din[`PIC_ICW4_AEOI];
                expect_icw4 <= 1'b0;
            end else if (hi_wr) begin
                // OCW1 once initialized
                mask <= din;
            end
            // RR low leaves the read select alone
            if (ocw3_wr && ocw.ocw3.rr) begin
                read_isr <= ocw.ocw3.ris;
            end
        end
    end

endmodule

// File: pic_irq_pkg.sv
`include "pic_macros.svh"

package pic_irq_pkg;

    // One bit per interrupt line, bit 0 is IR0
    typedef logic [`PIC_NUM_IR-1:0] irq_vec_t;

    // Line number, 0 is highest priority
    typedef logic [`PIC_NUM_W-1:0] irq_num_t;

    // Vector returned on the second acknowledge
    typedef logic [`PIC_DATA_W-1:0] vector_t;

    // Acknowledge sequence
    // FIRST after the first inta pulse
    // SECOND for the one cycle the vector is out
    typedef enum logic [1:0] {
        ACK_IDLE   = 2'd0,
        ACK_FIRST  = 2'd1,
        ACK_SECOND = 2'd2
    } ack_phase_t;

endpackage

// File: pic_cfg_pkg.sv
`include "pic_macros.svh"

package pic_cfg_pkg;

    // One word on the host data bus
    typedef logic [`PIC_DATA_W-1:0] pic_word_t;

    // Vector base, upper five bits of the vector
    typedef logic [`PIC_BASE_W-1:0] vec_base_t;

    // Command word with A0 low and ICW1 select clear
    // Bit 3 tells which of the two views holds
    typedef union packed {
        // OCW2 view, bit 3 clear
        struct packed {
            // Rotate, ignored in fixed priority
            logic                  r;
            // Specific level
            logic                  sl;
            // End of interrupt
            logic                  eoi;
            // ICW1 select and OCW3 select, both zero
            logic [1:0]            fixed_zero;
            // Line named by a specific command
            logic [`PIC_NUM_W-1:0] level;
        } ocw2;
        // OCW3 view, bit 3 set
        struct packed {
            logic                  rsvd;
            // Special mask mode enable and value
            logic [1:0]            mask_mode;
            // ICW1 select low, OCW3 select high
            logic [1:0]            sel;
            logic                  poll;
            // Read register enable
            logic                  rr;
            // ISR rather than IRR
            logic                  ris;
        } ocw3;
    } ocw23_u;

endpackage

// File: pic_macros.svh
`ifndef PIC_MACROS_SVH
`define PIC_MACROS_SVH

// Line count and widths
`define PIC_NUM_IR      8
// Bits needed for a line number
`define PIC_NUM_W       3
// Host bus word
`define PIC_DATA_W      8
// ICW2 vector base, bits 7..3 of the word
`define PIC_BASE_W      5

// ICW1 bit positions
`define PIC_ICW1_IC4    0
`define PIC_ICW1_LTIM   3
// Set in every ICW1 written with A0 low
`define PIC_ICW1_SEL    4

// ICW4 bit positions
`define PIC_ICW4_AEOI   1

// OCW2 or OCW3 when ICW1 select is clear
`define PIC_OCW_SEL3    3

// OCW2 bit positions
`define PIC_OCW2_EOI    5
`define PIC_OCW2_SL     6

// OCW3 bit positions
`define PIC_OCW3_RR     1
`define PIC_OCW3_RIS    0

`endif
